// File: source/nes_ctrl_macros.svh
`ifndef NES_CTRL_MACROS_SVH
`define NES_CTRL_MACROS_SVH

// Bus widths
`define NES_ADDR_WIDTH          8
`define NES_DATA_WIDTH          32
`define NES_HCI_ADDR_WIDTH      16
`define NES_HCI_STATUS_WIDTH    16

// Version reported in the version register
`define NES_VERSION_MAJOR       1
`define NES_VERSION_MINOR       0
`define NES_VERSION_REVISION    0
`define NES_MAJOR_RANGE         31:28
`define NES_MINOR_RANGE         27:20
`define NES_REVISION_RANGE      19:16

// Control register bits
`define NES_CTRL_HCI_RESET      0
`define NES_CTRL_CONSOLE_RESET  1

// Status register bits
`define NES_STAT_HCI_READY      1
`define NES_STAT_HCI_STATUS_LSB 16

`endif

// File: source/nes_ctrl_pkg.sv
`include "nes_ctrl_macros.svh"

package nes_ctrl_pkg;

  // Word addresses are the byte address without its two low bits
  typedef enum logic [`NES_ADDR_WIDTH-3:0] {
    REG_CONTROL          = 0,
    REG_STATUS           = 1,
    REG_USER_INPUT       = 2,
    REG_HCI_OPCODE_COUNT = 3,
    REG_HCI_OPCODE_ADDR  = 4,
    REG_HCI_OPCODE       = 5,
    REG_HCI_OPCODE_DATA  = 6,
    REG_HCI_READ_STB     = 7,
    REG_IMAGE_WIDTH      = 8,
    REG_IMAGE_HEIGHT     = 9,
    REG_IMAGE_SIZE       = 10,
    REG_VERSION          = 11
  } reg_addr_e;

  // Bus slave sequencing
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_REQ,
    ST_WR_RESP,
    ST_RD_REQ,
    ST_RD_RESP
  } axi_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// File: source/axi_lite_slave.sv
`include "nes_ctrl_macros.svh"

module axi_lite_slave
  import nes_ctrl_pkg::*;
(
  input  logic                            clk,
  input  logic                            w_axi_rst,

  // Write address and data channels
  input  logic                            i_awvalid,
  input  logic [`NES_ADDR_WIDTH-1:0]      i_awaddr,
  output logic                            o_awready,
  input  logic                            i_wvalid,
  input  logic [`NES_DATA_WIDTH-1:0]      i_wdata,
  output logic                            o_wready,

  // Write response channel
  output logic                            o_bvalid,
  output axi_resp_e                       o_bresp,
  input  logic                            i_bready,

  // Read address channel
  input  logic                            i_arvalid,
  input  logic [`NES_ADDR_WIDTH-1:0]      i_araddr,
  output logic                            o_arready,

  // Read data channel
  output logic                            o_rvalid,
  output axi_resp_e                       o_rresp,
  output logic [`NES_DATA_WIDTH-1:0]      o_rdata,
  input  logic                            i_rready,

  // Register request side
  output logic [`NES_ADDR_WIDTH-3:0]      o_reg_addr,
  output logic                            o_reg_wr_req,
  output logic [`NES_DATA_WIDTH-1:0]      o_reg_wr_data,
  input  logic                            i_reg_wr_ack,
  output logic                            o_reg_rd_req,
  input  logic                            i_reg_rd_ack,
  input  logic [`NES_DATA_WIDTH-1:0]      i_reg_rd_data,
  input  logic                            i_reg_invalid
);

  axi_state_e r_state;

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      r_state       <= ST_IDLE;
      o_awready     <= 1'b0;
      o_wready      <= 1'b0;
      o_bvalid      <= 1'b0;
      o_bresp       <= RESP_OKAY;
      o_arready     <= 1'b0;
      o_rvalid      <= 1'b0;
      o_rresp       <= RESP_OKAY;
      o_rdata       <= '0;
      o_reg_addr    <= '0;
      o_reg_wr_req  <= 1'b0;
      o_reg_wr_data <= '0;
      o_reg_rd_req  <= 1'b0;
    end else begin
      // Readies are single-cycle handshakes
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_arready <= 1'b0;

      case (r_state)
        ST_IDLE: begin
          // Writes win when both directions are pending
          if (i_awvalid && i_wvalid) begin
            o_awready     <= 1'b1;
            o_wready      <= 1'b1;
            o_reg_addr    <= i_awaddr[`NES_ADDR_WIDTH-1:2];
            o_reg_wr_data <= i_wdata;
            o_reg_wr_req  <= 1'b1;
            r_state       <= ST_WR_REQ;
          end else if (i_arvalid) begin
            o_arready    <= 1'b1;
            o_reg_addr   <= i_araddr[`NES_ADDR_WIDTH-1:2];
            o_reg_rd_req <= 1'b1;
            r_state      <= ST_RD_REQ;
          end
        end

        ST_WR_REQ: begin
          // Hold the request until the bank answers
          if (i_reg_wr_ack) begin
            o_reg_wr_req <= 1'b0;
            o_bvalid     <= 1'b1;
            o_bresp      <= i_reg_invalid ? RESP_SLVERR : RESP_OKAY;
            r_state      <= ST_WR_RESP;
          end
        end

        ST_WR_RESP: begin
          if (i_bready) begin
            o_bvalid <= 1'b0;
            r_state  <= ST_IDLE;
          end
        end

        ST_RD_REQ: begin
          if (i_reg_rd_ack) begin
            o_reg_rd_req <= 1'b0;
            o_rvalid     <= 1'b1;
            o_rdata      <= i_reg_rd_data;
            o_rresp      <= i_reg_invalid ? RESP_SLVERR : RESP_OKAY;
            r_state      <= ST_RD_RESP;
          end
        end

        ST_RD_RESP: begin
          // Data stays put while the master stalls
          if (i_rready) begin
            o_rvalid <= 1'b0;
            r_state  <= ST_IDLE;
          end
        end

        default: begin
          r_state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: source/nes_ctrl_regs.sv
`include "nes_ctrl_macros.svh"

module nes_ctrl_regs
  import nes_ctrl_pkg::*;
(
  input  logic                                clk,
  input  logic                                w_axi_rst,

  // Register request side
  input  logic [`NES_ADDR_WIDTH-3:0]          i_reg_addr,
  input  logic                                i_reg_wr_req,
  input  logic [`NES_DATA_WIDTH-1:0]          i_reg_wr_data,
  output logic                                o_reg_wr_ack,
  input  logic                                i_reg_rd_req,
  output logic                                o_reg_rd_ack,
  output logic [`NES_DATA_WIDTH-1:0]          o_reg_rd_data,
  output logic                                o_reg_invalid,

  // Console control
  output logic                                o_hci_reset,
  output logic                                o_console_reset,
  output logic [7:0]                          o_jp1_state,
  output logic [7:0]                          o_jp2_state,

  // HCI command side
  output logic [7:0]                          o_hci_opcode,
  output logic                                o_hci_opcode_stb,
  input  logic                                i_hci_opcode_ack,
  input  logic [`NES_HCI_STATUS_WIDTH-1:0]    i_hci_opcode_status,
  output logic [`NES_HCI_ADDR_WIDTH-1:0]      o_hci_address,
  output logic [`NES_DATA_WIDTH-1:0]          o_hci_count,
  output logic [7:0]                          o_hci_din,
  output logic                                o_hci_din_stb,
  input  logic                                i_hci_sm_ready,
  input  logic                                i_hci_dout_stb,
  input  logic [7:0]                          i_hci_dout,
  output logic                                o_hci_host_ready
);

  reg_addr_e                          w_addr;
  logic                               w_addr_invalid;
  logic [`NES_DATA_WIDTH-1:0]         w_control;
  logic [`NES_DATA_WIDTH-1:0]         w_status;
  logic [`NES_DATA_WIDTH-1:0]         w_version;
  logic [`NES_HCI_STATUS_WIDTH-1:0]   r_hci_status;
  logic [7:0]                         r_hci_dout;

  assign w_addr         = reg_addr_e'(i_reg_addr);
  assign w_addr_invalid = (i_reg_addr > REG_VERSION);

  // Read views of the packed registers
  always_comb begin
    w_control = '0;
    w_control[`NES_CTRL_HCI_RESET]     = o_hci_reset;
    w_control[`NES_CTRL_CONSOLE_RESET] = o_console_reset;

    // Clock-locked and new-status bits stay zero
    w_status = '0;
    w_status[`NES_STAT_HCI_READY] = i_hci_sm_ready;
    w_status[`NES_STAT_HCI_STATUS_LSB +: `NES_HCI_STATUS_WIDTH] = r_hci_status;

    w_version = '0;
    w_version[`NES_MAJOR_RANGE]    = `NES_VERSION_MAJOR;
    w_version[`NES_MINOR_RANGE]    = `NES_VERSION_MINOR;
    w_version[`NES_REVISION_RANGE] = `NES_VERSION_REVISION;
  end

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      o_reg_wr_ack     <= 1'b0;
      o_reg_rd_ack     <= 1'b0;
      o_reg_rd_data    <= '0;
      o_reg_invalid    <= 1'b0;
      o_hci_reset      <= 1'b1;
      o_console_reset  <= 1'b1;
      o_jp1_state      <= '0;
      o_jp2_state      <= '0;
      o_hci_opcode     <= '0;
      o_hci_opcode_stb <= 1'b0;
      o_hci_address    <= '0;
      o_hci_count      <= '0;
      o_hci_din        <= '0;
      o_hci_din_stb    <= 1'b0;
      o_hci_host_ready <= 1'b0;
      r_hci_status     <= '0;
      r_hci_dout       <= '0;
    end else begin
      // Acks and command strobes last one cycle
      o_reg_wr_ack     <= 1'b0;
      o_reg_rd_ack     <= 1'b0;
      o_reg_invalid    <= 1'b0;
      o_hci_opcode_stb <= 1'b0;
      o_hci_din_stb    <= 1'b0;
      o_hci_host_ready <= 1'b0;

      // Capture what the HCI returns
      if (i_hci_opcode_ack) begin
        r_hci_status <= i_hci_opcode_status;
      end
      if (i_hci_dout_stb) begin
        r_hci_dout <= i_hci_dout;
      end

      // Request is still high in the ack cycle, so skip it there
      if (i_reg_wr_req && !o_reg_wr_ack) begin
        case (w_addr)
          REG_CONTROL: begin
            o_hci_reset     <= i_reg_wr_data[`NES_CTRL_HCI_RESET];
            o_console_reset <= i_reg_wr_data[`NES_CTRL_CONSOLE_RESET];
          end
          REG_USER_INPUT: begin
            o_jp1_state <= i_reg_wr_data[7:0];
            o_jp2_state <= i_reg_wr_data[15:8];
          end
          REG_HCI_OPCODE_COUNT: o_hci_count <= i_reg_wr_data;
          REG_HCI_OPCODE_ADDR: begin
            o_hci_address <= i_reg_wr_data[`NES_HCI_ADDR_WIDTH-1:0];
          end
          REG_HCI_OPCODE: begin
            o_hci_opcode     <= i_reg_wr_data[7:0];
            o_hci_opcode_stb <= 1'b1;
          end
          REG_HCI_OPCODE_DATA: begin
            o_hci_din     <= i_reg_wr_data[7:0];
            o_hci_din_stb <= 1'b1;
          end
          REG_HCI_READ_STB: o_hci_host_ready <= i_reg_wr_data[0];
          default: begin
          end
        endcase
        o_reg_invalid <= w_addr_invalid;
        o_reg_wr_ack  <= 1'b1;
      end else if (i_reg_rd_req && !o_reg_rd_ack) begin
        case (w_addr)
          REG_CONTROL:          o_reg_rd_data <= w_control;
          REG_STATUS:           o_reg_rd_data <= w_status;
          REG_HCI_OPCODE_COUNT: o_reg_rd_data <= o_hci_count;
          REG_HCI_OPCODE_ADDR: begin
            o_reg_rd_data <= {{(`NES_DATA_WIDTH-`NES_HCI_ADDR_WIDTH){1'b0}}, o_hci_address};
          end
          REG_HCI_OPCODE:       o_reg_rd_data <= {24'h0, o_hci_opcode};
          REG_HCI_OPCODE_DATA:  o_reg_rd_data <= {24'h0, r_hci_dout};
          REG_VERSION:          o_reg_rd_data <= w_version;
          // Image registers, joypads and unmapped words read zero
          default:              o_reg_rd_data <= '0;
        endcase
        o_reg_invalid <= w_addr_invalid;
        o_reg_rd_ack  <= 1'b1;
      end
    end
  end

endmodule

// File: source/nes_ctrl_top.sv
`include "nes_ctrl_macros.svh"

module nes_ctrl_top (
  input  logic                                clk,
  input  logic                                w_axi_rst,

  // AXI-Lite slave port
  input  logic                                i_awvalid,
  input  logic [`NES_ADDR_WIDTH-1:0]          i_awaddr,
  output logic                                o_awready,
  input  logic                                i_wvalid,
  input  logic [`NES_DATA_WIDTH-1:0]          i_wdata,
  output logic                                o_wready,
  output logic                                o_bvalid,
  output logic [1:0]                          o_bresp,
  input  logic                                i_bready,
  input  logic                                i_arvalid,
  input  logic [`NES_ADDR_WIDTH-1:0]          i_araddr,
  output logic                                o_arready,
  output logic                                o_rvalid,
  output logic [1:0]                          o_rresp,
  output logic [`NES_DATA_WIDTH-1:0]          o_rdata,
  input  logic                                i_rready,

  // Console resets and joypads
  output logic                                o_hci_reset,
  output logic                                o_console_reset,
  output logic [7:0]                          o_jp1_state,
  output logic [7:0]                          o_jp2_state,

  // HCI
  output logic [7:0]                          o_hci_opcode,
  output logic                                o_hci_opcode_stb,
  input  logic                                i_hci_opcode_ack,
  input  logic [`NES_HCI_STATUS_WIDTH-1:0]    i_hci_opcode_status,
  output logic [`NES_HCI_ADDR_WIDTH-1:0]      o_hci_address,
  output logic [`NES_DATA_WIDTH-1:0]          o_hci_count,
  output logic [7:0]                          o_hci_din,
  output logic                                o_hci_din_stb,
  input  logic                                i_hci_sm_ready,
  input  logic                                i_hci_dout_stb,
  input  logic [7:0]                          i_hci_dout,
  output logic                                o_hci_host_ready
);

  logic [`NES_ADDR_WIDTH-3:0]   w_reg_addr;
  logic                         w_reg_wr_req;
  logic [`NES_DATA_WIDTH-1:0]   w_reg_wr_data;
  logic                         w_reg_wr_ack;
  logic                         w_reg_rd_req;
  logic                         w_reg_rd_ack;
  logic [`NES_DATA_WIDTH-1:0]   w_reg_rd_data;
  logic                         w_reg_invalid;

  // Bus transactions to single register requests
  axi_lite_slave u_slave (
    .clk           (clk),
    .w_axi_rst     (w_axi_rst),
    .i_awvalid     (i_awvalid),
    .i_awaddr      (i_awaddr),
    .o_awready     (o_awready),
    .i_wvalid      (i_wvalid),
    .i_wdata       (i_wdata),
    .o_wready      (o_wready),
    .o_bvalid      (o_bvalid),
    .o_bresp       (o_bresp),
    .i_bready      (i_bready),
    .i_arvalid     (i_arvalid),
    .i_araddr      (i_araddr),
    .o_arready     (o_arready),
    .o_rvalid      (o_rvalid),
    .o_rresp       (o_rresp),
    .o_rdata       (o_rdata),
    .i_rready      (i_rready),
    .o_reg_addr    (w_reg_addr),
    .o_reg_wr_req  (w_reg_wr_req),
    .o_reg_wr_data (w_reg_wr_data),
    .i_reg_wr_ack  (w_reg_wr_ack),
    .o_reg_rd_req  (w_reg_rd_req),
    .i_reg_rd_ack  (w_reg_rd_ack),
    .i_reg_rd_data (w_reg_rd_data),
    .i_reg_invalid (w_reg_invalid)
  );

  nes_ctrl_regs u_regs (
    .clk                 (clk),
    .w_axi_rst           (w_axi_rst),
    .i_reg_addr          (w_reg_addr),
    .i_reg_wr_req        (w_reg_wr_req),
    .i_reg_wr_data       (w_reg_wr_data),
    .o_reg_wr_ack        (w_reg_wr_ack),
    .i_reg_rd_req        (w_reg_rd_req),
    .o_reg_rd_ack        (w_reg_rd_ack),
    .o_reg_rd_data       (w_reg_rd_data),
    .o_reg_invalid       (w_reg_invalid),
    .o_hci_reset         (o_hci_reset),
    .o_console_reset     (o_console_reset),
    .o_jp1_state         (o_jp1_state),
    .o_jp2_state         (o_jp2_state),
    .o_hci_opcode        (o_hci_opcode),
    .o_hci_opcode_stb    (o_hci_opcode_stb),
    .i_hci_opcode_ack    (i_hci_opcode_ack),
    .i_hci_opcode_status (i_hci_opcode_status),
    .o_hci_address       (o_hci_address),
    .o_hci_count         (o_hci_count),
    .o_hci_din           (o_hci_din),
    .o_hci_din_stb       (o_hci_din_stb),
    .i_hci_sm_ready      (i_hci_sm_ready),
    .i_hci_dout_stb      (i_hci_dout_stb),
    .i_hci_dout          (i_hci_dout),
    .o_hci_host_ready    (o_hci_host_ready)
  );

endmodule

// File: bench/tb_nes_ctrl.sv
`include "nes_ctrl_macros.svh"

module tb_nes_ctrl
  import nes_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Up to 400 transactions of at most 40 cycles each, plus margin
  localparam int MAX_TRANSACTIONS       = 400;
  localparam int CYCLES_PER_TRANSACTION = 40;
  localparam int MARGIN_CYCLES          = 4000;
  localparam int TIMEOUT_CYCLES         = MAX_TRANSACTIONS * CYCLES_PER_TRANSACTION
                                          + MARGIN_CYCLES;

  logic                              clk;
  logic                              w_axi_rst;
  logic                              awvalid;
  logic [`NES_ADDR_WIDTH-1:0]        awaddr;
  logic                              wvalid;
  logic [`NES_DATA_WIDTH-1:0]        wdata;
  logic                              bready;
  logic                              arvalid;
  logic [`NES_ADDR_WIDTH-1:0]        araddr;
  logic                              rready;
  logic                              hci_opcode_ack;
  logic [`NES_HCI_STATUS_WIDTH-1:0]  hci_opcode_status;
  logic                              hci_sm_ready;
  logic                              hci_dout_stb;
  logic [7:0]                        hci_dout;

  logic                              o_awready;
  logic                              o_wready;
  logic                              o_bvalid;
  logic [1:0]                        o_bresp;
  logic                              o_arready;
  logic                              o_rvalid;
  logic [1:0]                        o_rresp;
  logic [`NES_DATA_WIDTH-1:0]        o_rdata;
  logic                              o_hci_reset;
  logic                              o_console_reset;
  logic [7:0]                        o_jp1_state;
  logic [7:0]                        o_jp2_state;
  logic [7:0]                        o_hci_opcode;
  logic                              o_hci_opcode_stb;
  logic [`NES_HCI_ADDR_WIDTH-1:0]    o_hci_address;
  logic [`NES_DATA_WIDTH-1:0]        o_hci_count;
  logic [7:0]                        o_hci_din;
  logic                              o_hci_din_stb;
  logic                              o_hci_host_ready;

  int seed;
  int errors;
  int checks;
  int test_num;
  int test_err_start;
  int stall_floor;
  int cycles;
  int opcode_pulses;
  int din_pulses;
  int ready_pulses;
  logic [7:0] opcode_seen;
  logic [7:0] din_seen;

  // Register model
  logic        m_hci_reset;
  logic        m_console_reset;
  logic [7:0]  m_jp1;
  logic [7:0]  m_jp2;
  logic [31:0] m_count;
  logic [15:0] m_address;
  logic [7:0]  m_opcode;
  logic [7:0]  m_din;
  logic [15:0] m_status;
  logic [7:0]  m_dout;
  logic        m_ready;

  nes_ctrl_top dut (
    .clk (clk), .w_axi_rst (w_axi_rst),
    .i_awvalid (awvalid), .i_awaddr (awaddr), .o_awready (o_awready),
    .i_wvalid (wvalid), .i_wdata (wdata), .o_wready (o_wready),
    .o_bvalid (o_bvalid), .o_bresp (o_bresp), .i_bready (bready),
    .i_arvalid (arvalid), .i_araddr (araddr), .o_arready (o_arready),
    .o_rvalid (o_rvalid), .o_rresp (o_rresp), .o_rdata (o_rdata), .i_rready (rready),
    .o_hci_reset (o_hci_reset), .o_console_reset (o_console_reset),
    .o_jp1_state (o_jp1_state), .o_jp2_state (o_jp2_state),
    .o_hci_opcode (o_hci_opcode), .o_hci_opcode_stb (o_hci_opcode_stb),
    .i_hci_opcode_ack (hci_opcode_ack), .i_hci_opcode_status (hci_opcode_status),
    .o_hci_address (o_hci_address), .o_hci_count (o_hci_count),
    .o_hci_din (o_hci_din), .o_hci_din_stb (o_hci_din_stb),
    .i_hci_sm_ready (hci_sm_ready), .i_hci_dout_stb (hci_dout_stb),
    .i_hci_dout (hci_dout), .o_hci_host_ready (o_hci_host_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: no result after %0d clock cycles, run stopped", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // Strobe counts sampled away from the active edge
  always @(negedge clk) begin
    if (o_hci_opcode_stb) begin
      opcode_pulses++;
      opcode_seen = o_hci_opcode;
    end
    if (o_hci_din_stb) begin
      din_pulses++;
      din_seen = o_hci_din;
    end
    if (o_hci_host_ready) begin
      ready_pulses++;
    end
  end

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp)
    else report_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  function automatic logic [81:0] output_state();
    return {o_hci_reset, o_console_reset, o_jp1_state, o_jp2_state,
            o_hci_address, o_hci_count, o_hci_opcode, o_hci_din};
  endfunction

  function automatic logic [31:0] expected_read(input logic [5:0] a);
    case (a)
      6'(REG_CONTROL):          return {30'd0, m_console_reset, m_hci_reset};
      6'(REG_STATUS):           return {m_status, 14'd0, m_ready, 1'b0};
      6'(REG_HCI_OPCODE_COUNT): return m_count;
      6'(REG_HCI_OPCODE_ADDR):  return {16'd0, m_address};
      6'(REG_HCI_OPCODE):       return {24'd0, m_opcode};
      6'(REG_HCI_OPCODE_DATA):  return {24'd0, m_dout};
      6'(REG_VERSION):          return 32'h1000_0000;
      default:                  return 32'd0;
    endcase
  endfunction

  task automatic model_write(input logic [5:0] a, input logic [31:0] d);
    case (a)
      6'(REG_CONTROL): begin
        m_hci_reset     = d[0];
        m_console_reset = d[1];
      end
      6'(REG_USER_INPUT): begin
        m_jp1 = d[7:0];
        m_jp2 = d[15:8];
      end
      6'(REG_HCI_OPCODE_COUNT): m_count = d;
      6'(REG_HCI_OPCODE_ADDR):  m_address = d[15:0];
      6'(REG_HCI_OPCODE):       m_opcode = d[7:0];
      6'(REG_HCI_OPCODE_DATA):  m_din = d[7:0];
      default: begin
      end
    endcase
  endtask

  task automatic check_outputs();
    check_value(32'(o_hci_reset), 32'(m_hci_reset), "o_hci_reset");
    check_value(32'(o_console_reset), 32'(m_console_reset), "o_console_reset");
    check_value(32'(o_jp1_state), 32'(m_jp1), "o_jp1_state");
    check_value(32'(o_jp2_state), 32'(m_jp2), "o_jp2_state");
    check_value(32'(o_hci_address), 32'(m_address), "o_hci_address");
    check_value(o_hci_count, m_count, "o_hci_count");
    check_value(32'(o_hci_opcode), 32'(m_opcode), "o_hci_opcode");
    check_value(32'(o_hci_din), 32'(m_din), "o_hci_din");
  endtask

  // Waits for bvalid or rvalid, stalls the master, then completes the handshake
  task automatic take_response(input bit is_write, output logic [1:0] resp,
                               output logic [31:0] data);
    int stall;
    int pulses;
    logic [81:0] snap;
    @(negedge clk);
    while (!(is_write ? o_bvalid : o_rvalid)) @(negedge clk);
    resp   = is_write ? o_bresp : o_rresp;
    data   = o_rdata;
    snap   = output_state();
    pulses = opcode_pulses + din_pulses + ready_pulses;
    stall  = $random(seed) & 3;
    if (stall < stall_floor) stall = stall_floor;
    repeat (stall) begin
      @(negedge clk);
      check_value(32'(is_write ? o_bvalid : o_rvalid), 32'd1, "valid during stall");
      check_value(32'(is_write ? o_bresp : o_rresp), 32'(resp), "response during stall");
      if (!is_write) check_value(o_rdata, data, "read data during stall");
      checks++;
      assert (output_state() == snap)
      else report_error("register outputs changed while the response was stalled");
    end
    @(posedge clk);
    #5;
    if (is_write) bready = 1'b1;
    else rready = 1'b1;
    @(posedge clk);
    #5;
    bready = 1'b0;
    rready = 1'b0;
    check_value(opcode_pulses + din_pulses + ready_pulses, pulses, "strobes during stall");
  endtask

  task automatic axi_write(input logic [5:0] a, input logic [31:0] d, output logic [1:0] resp);
    logic [31:0] unused_data;
    @(posedge clk);
    #5;
    awvalid = 1'b1;
    awaddr  = {a, 2'b00};
    wvalid  = 1'b1;
    wdata   = d;
    @(negedge clk);
    while (!o_awready) @(negedge clk);
    check_value(32'(o_wready), 32'd1, "wready with awready");
    @(posedge clk);
    #5;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    take_response(1'b1, resp, unused_data);
  endtask

  task automatic axi_read(input logic [5:0] a, output logic [1:0] resp, output logic [31:0] d);
    @(posedge clk);
    #5;
    arvalid = 1'b1;
    araddr  = {a, 2'b00};
    @(negedge clk);
    while (!o_arready) @(negedge clk);
    @(posedge clk);
    #5;
    arvalid = 1'b0;
    take_response(1'b0, resp, d);
  endtask

  task automatic write_check(input logic [5:0] a, input logic [31:0] d);
    int opc0;
    int din0;
    int rdy0;
    logic [1:0] resp;
    logic [1:0] exp_resp;
    opc0     = opcode_pulses;
    din0     = din_pulses;
    rdy0     = ready_pulses;
    exp_resp = (a > 6'd11) ? 2'(RESP_SLVERR) : 2'(RESP_OKAY);
    axi_write(a, d, resp);
    model_write(a, d);
    check_value(32'(resp), 32'(exp_resp), $sformatf("bresp for word %0d", a));
    check_value(opcode_pulses - opc0, (a == 6'(REG_HCI_OPCODE)) ? 1 : 0, "opcode strobes");
    check_value(din_pulses - din0, (a == 6'(REG_HCI_OPCODE_DATA)) ? 1 : 0, "data strobes");
    check_value(ready_pulses - rdy0, (a == 6'(REG_HCI_READ_STB) && d[0]) ? 1 : 0,
                "host ready pulses");
    if (a == 6'(REG_HCI_OPCODE)) check_value(32'(opcode_seen), 32'(d[7:0]), "strobed opcode");
    if (a == 6'(REG_HCI_OPCODE_DATA)) check_value(32'(din_seen), 32'(d[7:0]), "strobed data");
    check_outputs();
  endtask

  task automatic read_check(input logic [5:0] a);
    logic [1:0] resp;
    logic [1:0] exp_resp;
    logic [31:0] d;
    exp_resp = (a > 6'd11) ? 2'(RESP_SLVERR) : 2'(RESP_OKAY);
    axi_read(a, resp, d);
    check_value(32'(resp), 32'(exp_resp), $sformatf("rresp for word %0d", a));
    check_value(d, expected_read(a), $sformatf("read data of word %0d", a));
  endtask

  // HCI side returns a status on the opcode ack and a byte on the data strobe
  task automatic hci_respond();
    @(posedge clk);
    #5;
    hci_opcode_ack    = 1'b1;
    hci_opcode_status = 16'($random(seed));
    hci_sm_ready      = 1'($random(seed));
    @(posedge clk);
    #5;
    hci_opcode_ack = 1'b0;
    hci_dout_stb   = 1'b1;
    hci_dout       = 8'($random(seed));
    @(posedge clk);
    #5;
    hci_dout_stb = 1'b0;
    m_status     = hci_opcode_status;
    m_ready      = hci_sm_ready;
    m_dout       = hci_dout;
  endtask

  function automatic logic [5:0] pick_rw_addr(input int idx);
    case (idx)
      0:       return 6'(REG_CONTROL);
      1:       return 6'(REG_USER_INPUT);
      2:       return 6'(REG_HCI_OPCODE_COUNT);
      3:       return 6'(REG_HCI_OPCODE_ADDR);
      default: return 6'(REG_HCI_OPCODE);
    endcase
  endfunction

  task automatic end_test(input string name);
    test_num++;
    $display("Test %0d %s: %s", test_num, name,
             (errors == test_err_start) ? "passed" : "FAILED");
    test_err_start = errors;
  endtask

  initial begin
    logic [5:0] a;
    seed = 44867;
    errors = 0;
    checks = 0;
    test_num = 0;
    test_err_start = 0;
    stall_floor = 0;
    opcode_pulses = 0;
    din_pulses = 0;
    ready_pulses = 0;
    w_axi_rst = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    hci_opcode_ack = 1'b0;
    hci_opcode_status = '0;
    hci_sm_ready = 1'b0;
    hci_dout_stb = 1'b0;
    hci_dout = '0;
    m_hci_reset = 1'b1;
    m_console_reset = 1'b1;
    {m_jp1, m_jp2, m_count, m_address, m_opcode, m_din} = '0;
    {m_status, m_dout, m_ready} = '0;
    repeat (2) @(posedge clk);
    #5;
    w_axi_rst = 1'b0;

    read_check(6'(REG_CONTROL));
    read_check(6'(REG_VERSION));
    end_test("reset values");

    for (int i = 0; i < 40; i++) begin
      a = pick_rw_addr(($random(seed) & 32'h7fff_ffff) % 5);
      write_check(a, $random(seed));
      read_check(a);
    end
    end_test("random register writes and reads");

    for (int i = 0; i < 40; i++) begin
      write_check(6'(($random(seed) & 32'h7fff_ffff) % 12), $random(seed));
    end
    end_test("command strobes");

    for (int i = 0; i < 10; i++) begin
      hci_respond();
      read_check(6'(REG_STATUS));
      read_check(6'(REG_HCI_OPCODE_DATA));
    end
    end_test("HCI status and data capture");

    for (int i = 0; i < 10; i++) begin
      a = 6'(12 + ($random(seed) & 32'h7fff_ffff) % 52);
      write_check(a, $random(seed));
      read_check(a);
    end
    for (int j = 0; j < 12; j++) begin
      read_check(6'(j));
    end
    end_test("invalid addresses");

    // Longest stall on every response
    stall_floor = 3;
    for (int i = 0; i < 10; i++) begin
      a = pick_rw_addr(($random(seed) & 32'h7fff_ffff) % 5);
      write_check(a, $random(seed));
      read_check(a);
    end
    stall_floor = 0;
    end_test("response back-pressure");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+source
source/nes_ctrl_pkg.sv
source/axi_lite_slave.sv
source/nes_ctrl_regs.sv
source/nes_ctrl_top.sv
bench/tb_nes_ctrl.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_nes_ctrl
FILELIST   = sim.f
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation finished: FAIL
PASS_MSG   = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
